// File: src/gt_reset_pkg.sv
// GT reset package with the sequencer state encodings and synchronizer depths.
package gt_reset_pkg;

    // flop depth of the status and control synchronizers.
    localparam int SYNC_STAGES = 2;

    // flop depth of the reset request synchronizer.
    localparam int RESET_SYNC_STAGES = 4;

    // receive sequencer states.
    typedef enum logic [2:0] {
        RX_RESET       = 3'd0,
        RX_WAIT_LOCK   = 3'd1,
        RX_WAIT_CDR    = 3'd2,
        RX_WAIT_USRCLK = 3'd3,
        RX_DONE        = 3'd4
    } rx_state_t;

    // transmit sequencer states.
    // there is no CDR phase on this side.
    typedef enum logic [1:0] {
        TX_RESET       = 2'd0,
        TX_WAIT_LOCK   = 2'd1,
        TX_WAIT_USRCLK = 2'd2,
        TX_DONE        = 2'd3
    } tx_state_t;

endpackage

// File: src/sync_signal.sv
// Multi-bit flop-chain synchronizer that brings level signals into a destination clock.
`timescale 1ns/100ps

module sync_signal
    import gt_reset_pkg::*;
#(
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    // each bit goes through its own chain.
    // the bits are not guaranteed to arrive on the same edge.
    logic [WIDTH-1:0] chain [SYNC_STAGES];

    always_ff @(posedge clk) begin
        chain[0] <= in;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            chain[i] <= chain[i-1];
        end
    end

    assign out = chain[SYNC_STAGES-1];

endmodule

// File: src/sync_reset.sv
// Reset synchronizer that asserts at once and releases in step with clk.
`timescale 1ns/100ps

module sync_reset
    import gt_reset_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic out
);

    logic [RESET_SYNC_STAGES-1:0] chain;

    // the request sets the whole chain at once.
    // release waits until zeros have shifted through every stage.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            chain <= '1;
        end else begin
            chain <= {chain[RESET_SYNC_STAGES-2:0], 1'b0};
        end
    end

    assign out = chain[RESET_SYNC_STAGES-1];

endmodule

// File: src/gt_rx_reset.sv
// Receive reset sequencer that steps the GT receiver through PLL lock, CDR lock and user clock.
`timescale 1ns/100ps

module gt_rx_reset
    import gt_reset_pkg::*;
#(
    parameter int CNT_W     = 8,
    parameter int CDR_CNT_W = 20,
    parameter bit RX_PD     = 1'b0,
    parameter bit QPLL_SEL  = 1'b0,
    parameter bit LPM_EN    = 1'b0
) (
    input  logic clk,
    input  logic rst,

    input  logic gt_rxusrclk2,
    input  logic gt_rx_reset_done,
    input  logic gt_userclk_rx_active,
    input  logic gt_rx_pma_reset_done,
    input  logic gt_rx_prgdiv_reset_done,
    input  logic gt_rx_cdr_lock,
    input  logic qpll0_lock,
    input  logic qpll1_lock,

    input  logic rx_reset,
    input  logic rx_pma_reset,
    input  logic rx_pcs_reset,
    input  logic rx_dfe_lpm_reset,
    input  logic eyescan_reset,
    input  logic rx_pd,
    input  logic rx_qpll_sel,
    input  logic rx_lpm_en,

    output logic gt_rx_pd,
    output logic gt_rx_reset,
    output logic gt_rx_pma_reset,
    output logic gt_rx_dfe_lpm_reset,
    output logic gt_rx_eyescan_reset,
    output logic gt_rx_pcs_reset,
    output logic gt_rx_prgdiv_reset,
    output logic gt_rx_qpll_sel,
    output logic gt_rx_userrdy,
    output logic gt_rx_lpm_en,
    output logic rx_reset_done,
    output logic rx_pma_reset_done,
    output logic rx_prgdiv_reset_done
);

    logic             reset_done_sync;
    logic             pma_done_sync;
    logic             prgdiv_done_sync;
    logic             usrclk_active_sync;
    logic             cdr_lock_sync;
    logic             rx_reset_sync;
    logic             pd_reg;
    logic             sel_lock;
    logic             restart;
    rx_state_t        state;
    logic [CNT_W-1:0]     cnt;
    logic [CDR_CNT_W-1:0] cdr_cnt;

    sync_signal #(.WIDTH(5)) status_sync_i (
        .clk (clk),
        .in  ({gt_rx_reset_done, gt_rx_pma_reset_done, gt_rx_prgdiv_reset_done,
               gt_userclk_rx_active, gt_rx_cdr_lock}),
        .out ({reset_done_sync, pma_done_sync, prgdiv_done_sync,
               usrclk_active_sync, cdr_lock_sync})
    );

    // power-down goes to the transceiver in its own user clock domain.
    sync_signal #(.WIDTH(1)) pd_sync_i (
        .clk (gt_rxusrclk2),
        .in  (pd_reg),
        .out (gt_rx_pd)
    );

    sync_reset reset_sync_i (
        .clk (clk),
        .rst (rx_reset),
        .out (rx_reset_sync)
    );

    assign sel_lock = gt_rx_qpll_sel ? qpll1_lock : qpll0_lock;

    // a changed select or equalizer mode needs a full pass through reset.
    assign restart = rx_reset_sync || rx_pd || !sel_lock ||
                     (rx_qpll_sel != gt_rx_qpll_sel) || (rx_lpm_en != gt_rx_lpm_en);

    assign rx_pma_reset_done    = pma_done_sync;
    assign rx_prgdiv_reset_done = prgdiv_done_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            state               <= RX_RESET;
            cnt                 <= '0;
            cdr_cnt             <= '0;
            gt_rx_reset         <= 1'b1;
            gt_rx_prgdiv_reset  <= 1'b1;
            gt_rx_userrdy       <= 1'b0;
            rx_reset_done       <= 1'b0;
            gt_rx_pma_reset     <= 1'b0;
            gt_rx_pcs_reset     <= 1'b0;
            gt_rx_dfe_lpm_reset <= 1'b0;
            gt_rx_eyescan_reset <= 1'b0;
            pd_reg              <= RX_PD;
            gt_rx_qpll_sel      <= QPLL_SEL;
            gt_rx_lpm_en        <= LPM_EN;
        end else begin
            gt_rx_pma_reset     <= rx_pma_reset;
            gt_rx_pcs_reset     <= rx_pcs_reset;
            gt_rx_dfe_lpm_reset <= rx_dfe_lpm_reset;
            gt_rx_eyescan_reset <= eyescan_reset;

            gt_rx_reset        <= 1'b1;
            gt_rx_prgdiv_reset <= 1'b1;
            gt_rx_userrdy      <= 1'b0;
            rx_reset_done      <= 1'b0;
            cnt                <= '0;
            cdr_cnt            <= '0;

            case (state)
                RX_RESET: begin
                    // configuration is only sampled here.
                    pd_reg         <= rx_pd;
                    gt_rx_qpll_sel <= rx_qpll_sel;
                    gt_rx_lpm_en   <= rx_lpm_en;
                    state          <= RX_WAIT_LOCK;
                end
                RX_WAIT_LOCK: begin
                    if (sel_lock) begin
                        cnt <= cnt + 1'b1;
                        if (&cnt) begin
                            state <= RX_WAIT_CDR;
                        end
                    end
                end
                RX_WAIT_CDR: begin
                    gt_rx_reset <= 1'b0;
                    cdr_cnt     <= cdr_cnt + 1'b1;
                    if (cdr_lock_sync) begin
                        cnt <= cnt + 1'b1;
                    end
                    // without CDR lock the timeout still moves the sequence on.
                    if ((cdr_lock_sync && &cnt) || &cdr_cnt) begin
                        cnt   <= '0;
                        state <= RX_WAIT_USRCLK;
                    end
                end
                RX_WAIT_USRCLK: begin
                    gt_rx_reset        <= 1'b0;
                    gt_rx_prgdiv_reset <= 1'b0;
                    if (usrclk_active_sync) begin
                        cnt <= cnt + 1'b1;
                        if (&cnt) begin
                            state <= RX_DONE;
                        end
                    end
                end
                RX_DONE: begin
                    gt_rx_reset        <= 1'b0;
                    gt_rx_prgdiv_reset <= 1'b0;
                    gt_rx_userrdy      <= 1'b1;
                    rx_reset_done      <= reset_done_sync && prgdiv_done_sync;
                end
                default: begin
                    state <= RX_RESET;
                end
            endcase

            if (restart) begin
                state <= RX_RESET;
            end
        end
    end

endmodule

// File: src/gt_tx_reset.sv
// Transmit reset sequencer that steps the GT transmitter through PLL lock and user clock.
`timescale 1ns/100ps

module gt_tx_reset
    import gt_reset_pkg::*;
#(
    parameter int CNT_W    = 8,
    parameter bit TX_PD    = 1'b0,
    parameter bit QPLL_SEL = 1'b0
) (
    input  logic clk,
    input  logic rst,

    input  logic gt_txusrclk2,
    input  logic gt_tx_reset_done,
    input  logic gt_userclk_tx_active,
    input  logic gt_tx_pma_reset_done,
    input  logic gt_tx_prgdiv_reset_done,
    input  logic qpll0_lock,
    input  logic qpll1_lock,

    input  logic tx_reset,
    input  logic tx_pma_reset,
    input  logic tx_pcs_reset,
    input  logic tx_pd,
    input  logic tx_qpll_sel,

    output logic gt_tx_pd,
    output logic gt_tx_reset,
    output logic gt_tx_pma_reset,
    output logic gt_tx_pcs_reset,
    output logic gt_tx_prgdiv_reset,
    output logic gt_tx_qpll_sel,
    output logic gt_tx_userrdy,
    output logic tx_reset_done,
    output logic tx_pma_reset_done,
    output logic tx_prgdiv_reset_done
);

    logic             reset_done_sync;
    logic             pma_done_sync;
    logic             prgdiv_done_sync;
    logic             usrclk_active_sync;
    logic             tx_reset_sync;
    logic             pd_reg;
    logic             sel_lock;
    logic             restart;
    tx_state_t        state;
    logic [CNT_W-1:0] cnt;

    sync_signal #(.WIDTH(4)) status_sync_i (
        .clk (clk),
        .in  ({gt_tx_reset_done, gt_tx_pma_reset_done, gt_tx_prgdiv_reset_done,
               gt_userclk_tx_active}),
        .out ({reset_done_sync, pma_done_sync, prgdiv_done_sync, usrclk_active_sync})
    );

    sync_signal #(.WIDTH(1)) pd_sync_i (
        .clk (gt_txusrclk2),
        .in  (pd_reg),
        .out (gt_tx_pd)
    );

    sync_reset reset_sync_i (
        .clk (clk),
        .rst (tx_reset),
        .out (tx_reset_sync)
    );

    assign sel_lock = gt_tx_qpll_sel ? qpll1_lock : qpll0_lock;
    assign restart  = tx_reset_sync || tx_pd || !sel_lock || (tx_qpll_sel != gt_tx_qpll_sel);

    assign tx_pma_reset_done    = pma_done_sync;
    assign tx_prgdiv_reset_done = prgdiv_done_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= TX_RESET;
            cnt                <= '0;
            gt_tx_reset        <= 1'b1;
            gt_tx_prgdiv_reset <= 1'b1;
            gt_tx_userrdy      <= 1'b0;
            tx_reset_done      <= 1'b0;
            gt_tx_pma_reset    <= 1'b0;
            gt_tx_pcs_reset    <= 1'b0;
            pd_reg             <= TX_PD;
            gt_tx_qpll_sel     <= QPLL_SEL;
        end else begin
            gt_tx_pma_reset <= tx_pma_reset;
            gt_tx_pcs_reset <= tx_pcs_reset;

            gt_tx_reset        <= 1'b1;
            gt_tx_prgdiv_reset <= 1'b1;
            gt_tx_userrdy      <= 1'b0;
            tx_reset_done      <= 1'b0;
            cnt                <= '0;

            case (state)
                TX_RESET: begin
                    pd_reg         <= tx_pd;
                    gt_tx_qpll_sel <= tx_qpll_sel;
                    state          <= TX_WAIT_LOCK;
                end
                TX_WAIT_LOCK: begin
                    if (sel_lock) begin
                        cnt <= cnt + 1'b1;
                        if (&cnt) begin
                            state <= TX_WAIT_USRCLK;
                        end
                    end
                end
                TX_WAIT_USRCLK: begin
                    // the divider comes out of reset along with the main reset.
                    gt_tx_reset        <= 1'b0;
                    gt_tx_prgdiv_reset <= 1'b0;
                    if (usrclk_active_sync) begin
                        cnt <= cnt + 1'b1;
                        if (&cnt) begin
                            state <= TX_DONE;
                        end
                    end
                end
                TX_DONE: begin
                    gt_tx_reset        <= 1'b0;
                    gt_tx_prgdiv_reset <= 1'b0;
                    gt_tx_userrdy      <= 1'b1;
                    tx_reset_done      <= reset_done_sync && prgdiv_done_sync;
                end
                default: begin
                    state <= TX_RESET;
                end
            endcase

            if (restart) begin
                state <= TX_RESET;
            end
        end
    end

endmodule

// File: src/gt_reset_top.sv
// Lane reset top level joining the receive and transmit sequencers on shared PLL lock inputs.
`timescale 1ns/100ps

module gt_reset_top #(
    parameter int CNT_W     = 8,
    parameter int CDR_CNT_W = 20,
    parameter bit RX_PD     = 1'b0,
    parameter bit TX_PD     = 1'b0,
    parameter bit QPLL_SEL  = 1'b0,
    parameter bit LPM_EN    = 1'b0
) (
    input  logic clk,
    input  logic rst,
    input  logic qpll0_lock,
    input  logic qpll1_lock,

    input  logic gt_rxusrclk2,
    input  logic gt_rx_reset_done,
    input  logic gt_userclk_rx_active,
    input  logic gt_rx_pma_reset_done,
    input  logic gt_rx_prgdiv_reset_done,
    input  logic gt_rx_cdr_lock,
    input  logic rx_reset,
    input  logic rx_pma_reset,
    input  logic rx_pcs_reset,
    input  logic rx_dfe_lpm_reset,
    input  logic eyescan_reset,
    input  logic rx_pd,
    input  logic rx_qpll_sel,
    input  logic rx_lpm_en,
    output logic gt_rx_pd,
    output logic gt_rx_reset,
    output logic gt_rx_pma_reset,
    output logic gt_rx_dfe_lpm_reset,
    output logic gt_rx_eyescan_reset,
    output logic gt_rx_pcs_reset,
    output logic gt_rx_prgdiv_reset,
    output logic gt_rx_qpll_sel,
    output logic gt_rx_userrdy,
    output logic gt_rx_lpm_en,
    output logic rx_reset_done,
    output logic rx_pma_reset_done,
    output logic rx_prgdiv_reset_done,

    input  logic gt_txusrclk2,
    input  logic gt_tx_reset_done,
    input  logic gt_userclk_tx_active,
    input  logic gt_tx_pma_reset_done,
    input  logic gt_tx_prgdiv_reset_done,
    input  logic tx_reset,
    input  logic tx_pma_reset,
    input  logic tx_pcs_reset,
    input  logic tx_pd,
    input  logic tx_qpll_sel,
    output logic gt_tx_pd,
    output logic gt_tx_reset,
    output logic gt_tx_pma_reset,
    output logic gt_tx_pcs_reset,
    output logic gt_tx_prgdiv_reset,
    output logic gt_tx_qpll_sel,
    output logic gt_tx_userrdy,
    output logic tx_reset_done,
    output logic tx_pma_reset_done,
    output logic tx_prgdiv_reset_done
);

    // both sides see the same pair of PLL lock bits and pick one with their own select.
    gt_rx_reset #(
        .CNT_W     (CNT_W),
        .CDR_CNT_W (CDR_CNT_W),
        .RX_PD     (RX_PD),
        .QPLL_SEL  (QPLL_SEL),
        .LPM_EN    (LPM_EN)
    ) rx_reset_i (
        .clk                     (clk),
        .rst                     (rst),
        .gt_rxusrclk2            (gt_rxusrclk2),
        .gt_rx_reset_done        (gt_rx_reset_done),
        .gt_userclk_rx_active    (gt_userclk_rx_active),
        .gt_rx_pma_reset_done    (gt_rx_pma_reset_done),
        .gt_rx_prgdiv_reset_done (gt_rx_prgdiv_reset_done),
        .gt_rx_cdr_lock          (gt_rx_cdr_lock),
        .qpll0_lock              (qpll0_lock),
        .qpll1_lock              (qpll1_lock),
        .rx_reset                (rx_reset),
        .rx_pma_reset            (rx_pma_reset),
        .rx_pcs_reset            (rx_pcs_reset),
        .rx_dfe_lpm_reset        (rx_dfe_lpm_reset),
        .eyescan_reset           (eyescan_reset),
        .rx_pd                   (rx_pd),
        .rx_qpll_sel             (rx_qpll_sel),
        .rx_lpm_en               (rx_lpm_en),
        .gt_rx_pd                (gt_rx_pd),
        .gt_rx_reset             (gt_rx_reset),
        .gt_rx_pma_reset         (gt_rx_pma_reset),
        .gt_rx_dfe_lpm_reset     (gt_rx_dfe_lpm_reset),
        .gt_rx_eyescan_reset     (gt_rx_eyescan_reset),
        .gt_rx_pcs_reset         (gt_rx_pcs_reset),
        .gt_rx_prgdiv_reset      (gt_rx_prgdiv_reset),
        .gt_rx_qpll_sel          (gt_rx_qpll_sel),
        .gt_rx_userrdy           (gt_rx_userrdy),
        .gt_rx_lpm_en            (gt_rx_lpm_en),
        .rx_reset_done           (rx_reset_done),
        .rx_pma_reset_done       (rx_pma_reset_done),
        .rx_prgdiv_reset_done    (rx_prgdiv_reset_done)
    );

    gt_tx_reset #(
        .CNT_W    (CNT_W),
        .TX_PD    (TX_PD),
        .QPLL_SEL (QPLL_SEL)
    ) tx_reset_i (
        .clk                     (clk),
        .rst                     (rst),
        .gt_txusrclk2            (gt_txusrclk2),
        .gt_tx_reset_done        (gt_tx_reset_done),
        .gt_userclk_tx_active    (gt_userclk_tx_active),
        .gt_tx_pma_reset_done    (gt_tx_pma_reset_done),
        .gt_tx_prgdiv_reset_done (gt_tx_prgdiv_reset_done),
        .qpll0_lock              (qpll0_lock),
        .qpll1_lock              (qpll1_lock),
        .tx_reset                (tx_reset),
        .tx_pma_reset            (tx_pma_reset),
        .tx_pcs_reset            (tx_pcs_reset),
        .tx_pd                   (tx_pd),
        .tx_qpll_sel             (tx_qpll_sel),
        .gt_tx_pd                (gt_tx_pd),
        .gt_tx_reset             (gt_tx_reset),
        .gt_tx_pma_reset         (gt_tx_pma_reset),
        .gt_tx_pcs_reset         (gt_tx_pcs_reset),
        .gt_tx_prgdiv_reset      (gt_tx_prgdiv_reset),
        .gt_tx_qpll_sel          (gt_tx_qpll_sel),
        .gt_tx_userrdy           (gt_tx_userrdy),
        .tx_reset_done           (tx_reset_done),
        .tx_pma_reset_done       (tx_pma_reset_done),
        .tx_prgdiv_reset_done    (tx_prgdiv_reset_done)
    );

endmodule

// File: testbench/gt_reset_tb.sv
// Testbench for the lane reset sequencer with a small GT response model and file-driven tests.
`timescale 1ns/100ps

module gt_reset_tb;

    localparam int CNT_W     = 3;
    localparam int CDR_CNT_W = 6;
    // lock settle, CDR timeout and user clock settle, plus the model delays and sync stages.
    localparam int SEQ_WINDOW = 4 + 3 * (1 << CNT_W) + (1 << CDR_CNT_W) + 32;

    logic clk, rst, qpll0_lock, qpll1_lock;
    logic gt_rxusrclk2, gt_rx_reset_done, gt_userclk_rx_active, gt_rx_pma_reset_done;
    logic gt_rx_prgdiv_reset_done, gt_rx_cdr_lock;
    logic rx_reset, rx_pma_reset, rx_pcs_reset, rx_dfe_lpm_reset, eyescan_reset;
    logic rx_pd, rx_qpll_sel, rx_lpm_en;
    logic gt_rx_pd, gt_rx_reset, gt_rx_pma_reset, gt_rx_dfe_lpm_reset, gt_rx_eyescan_reset;
    logic gt_rx_pcs_reset, gt_rx_prgdiv_reset, gt_rx_qpll_sel, gt_rx_userrdy, gt_rx_lpm_en;
    logic rx_reset_done, rx_pma_reset_done, rx_prgdiv_reset_done;
    logic gt_txusrclk2, gt_tx_reset_done, gt_userclk_tx_active, gt_tx_pma_reset_done;
    logic gt_tx_prgdiv_reset_done;
    logic tx_reset, tx_pma_reset, tx_pcs_reset, tx_pd, tx_qpll_sel;
    logic gt_tx_pd, gt_tx_reset, gt_tx_pma_reset, gt_tx_pcs_reset, gt_tx_prgdiv_reset;
    logic gt_tx_qpll_sel, gt_tx_userrdy, tx_reset_done, tx_pma_reset_done, tx_prgdiv_reset_done;

    int         t_code[$];
    int         t_arg[$];
    bit         t_cdr[$];
    logic [3:0] t_exp[$];

    integer seed = 32'h8ad1;
    int     errors = 0;
    int     test_errors = 0;
    int     passed = 0;
    int     failed = 0;
    int     cycles = 0;
    int     cycle_limit = 0;
    bit     loaded = 0;

    // response model state.
    // each age counts clk cycles since a GT reset was released.
    bit cdr_en = 1;
    int done_dly = 1;
    int clk_dly = 1;
    int cdr_dly = 1;
    int rx_age = 0;
    int rx_div = 0;
    int tx_age = 0;
    int tx_div = 0;

    gt_reset_top #(
        .CNT_W     (CNT_W),
        .CDR_CNT_W (CDR_CNT_W)
    ) gt_reset_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // user clocks run 2 ns behind clk.
    initial begin
        gt_rxusrclk2 = 1'b0;
        #2;
        forever #4 gt_rxusrclk2 = ~gt_rxusrclk2;
    end

    initial begin
        gt_txusrclk2 = 1'b0;
        #2;
        forever #4 gt_txusrclk2 = ~gt_txusrclk2;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run stopped by the cycle limit of %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic int age_next(input logic held, input int age);
        if (held !== 1'b0) begin
            return 0;
        end
        return (age < 255) ? age + 1 : age;
    endfunction

    // the GT answers its resets a few cycles after they are released.
    always @(posedge clk) begin
        #1;
        rx_age = age_next(gt_rx_reset, rx_age);
        rx_div = age_next(gt_rx_prgdiv_reset, rx_div);
        tx_age = age_next(gt_tx_reset, tx_age);
        tx_div = age_next(gt_tx_prgdiv_reset, tx_div);
        gt_rx_reset_done        = rx_age >= done_dly;
        gt_rx_cdr_lock          = cdr_en && (rx_age >= cdr_dly);
        gt_rx_prgdiv_reset_done = rx_div >= done_dly;
        gt_userclk_rx_active    = rx_div >= done_dly + clk_dly;
        gt_rx_pma_reset_done    = gt_rx_pma_reset === 1'b0;
        gt_tx_reset_done        = tx_age >= done_dly;
        gt_tx_prgdiv_reset_done = tx_div >= done_dly;
        gt_userclk_tx_active    = tx_div >= done_dly + clk_dly;
        gt_tx_pma_reset_done    = gt_tx_pma_reset === 1'b0;
    end

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            note_error();
        end
    endtask

    task automatic check_rx_down();
        check_bit("rx_reset_done", rx_reset_done, 1'b0);
        check_bit("gt_rx_userrdy", gt_rx_userrdy, 1'b0);
        check_bit("gt_rx_reset", gt_rx_reset, 1'b1);
    endtask

    task automatic check_tx_down();
        check_bit("tx_reset_done", tx_reset_done, 1'b0);
        check_bit("gt_tx_userrdy", gt_tx_userrdy, 1'b0);
        check_bit("gt_tx_reset", gt_tx_reset, 1'b1);
    endtask

    // waits for the done and ready levels and can also watch that tx stays done.
    task automatic wait_settle(input logic [3:0] exp, input bit tx_hold, output int waited);
        waited = 0;
        while ({rx_reset_done, gt_rx_userrdy, tx_reset_done, gt_tx_userrdy} !== exp &&
               waited < SEQ_WINDOW) begin
            step(1);
            waited++;
            if (tx_hold) begin
                check_bit("tx_reset_done", tx_reset_done, 1'b1);
            end
        end
        if ({rx_reset_done, gt_rx_userrdy, tx_reset_done, gt_tx_userrdy} !== exp) begin
            $display("done and ready outputs did not settle within %0d cycles", SEQ_WINDOW);
            note_error();
        end
    endtask

    task automatic power_up(input logic [3:0] exp);
        int waited;
        qpll0_lock = 1'b0;
        qpll1_lock = 1'b0;
        rst = 1'b1;
        step(5);
        rst = 1'b0;
        check_rx_down();
        check_tx_down();
        check_bit("gt_rx_prgdiv_reset", gt_rx_prgdiv_reset, 1'b1);
        check_bit("gt_tx_prgdiv_reset", gt_tx_prgdiv_reset, 1'b1);
        check_bit("gt_rx_pma_reset", gt_rx_pma_reset, 1'b0);
        check_bit("gt_rx_qpll_sel", gt_rx_qpll_sel, 1'b0);
        step(1 + ($random(seed) & 7));
        qpll0_lock = 1'b1;
        qpll1_lock = 1'b1;
        wait_settle(exp, 1'b0, waited);
    endtask

    task automatic lock_loss(input int arg, input logic [3:0] exp);
        int waited;
        qpll0_lock = 1'b0;
        qpll1_lock = 1'b0;
        step(2);
        check_rx_down();
        check_tx_down();
        if (arg > 2) begin
            step(arg - 2);
        end
        qpll0_lock = 1'b1;
        qpll1_lock = 1'b1;
        wait_settle(exp, 1'b0, waited);
    endtask

    task automatic sel_change(input int arg, input logic [3:0] exp);
        int waited;
        rx_qpll_sel = arg[0];
        step(2);
        check_rx_down();
        check_bit("gt_rx_qpll_sel", gt_rx_qpll_sel, arg[0]);
        check_bit("tx_reset_done", tx_reset_done, 1'b1);
        wait_settle(exp, 1'b1, waited);
    endtask

    task automatic cdr_restart(input logic [3:0] exp);
        int waited;
        rx_reset = 1'b1;
        step(1);
        rx_reset = 1'b0;
        step(1);
        check_rx_down();
        wait_settle(exp, 1'b1, waited);
        if (!cdr_en && waited + 2 < (1 << CDR_CNT_W)) begin
            $display("rx side finished %0d cycles after restart, before the CDR timeout",
                     waited + 2);
            note_error();
        end else if (cdr_en && waited + 2 >= (1 << CDR_CNT_W)) begin
            $display("rx side took %0d cycles after restart although the CDR was locked",
                     waited + 2);
            note_error();
        end
    endtask

    task automatic pd_hold(input int arg, input logic [3:0] exp);
        int waited;
        rx_pd = 1'b1;
        step(8);
        check_rx_down();
        check_bit("gt_rx_pd", gt_rx_pd, 1'b1);
        check_bit("tx_reset_done", tx_reset_done, 1'b1);
        // a zero argument leaves the receiver powered down.
        if (arg != 0) begin
            if (arg > 8) begin
                step(arg - 8);
            end
            rx_pd = 1'b0;
        end
        wait_settle(exp, 1'b1, waited);
    endtask

    task automatic reset_pulse(input int arg, input logic [3:0] exp);
        logic [3:0] bits;
        int         waited;
        bits = arg[3:0];
        {eyescan_reset, rx_dfe_lpm_reset, rx_pcs_reset, rx_pma_reset} = bits;
        {tx_pcs_reset, tx_pma_reset} = bits[1:0];
        rx_reset = 1'b1;
        step(1);
        check_bit("gt_rx_pma_reset", gt_rx_pma_reset, bits[0]);
        check_bit("gt_rx_pcs_reset", gt_rx_pcs_reset, bits[1]);
        check_bit("gt_rx_dfe_lpm_reset", gt_rx_dfe_lpm_reset, bits[2]);
        check_bit("gt_rx_eyescan_reset", gt_rx_eyescan_reset, bits[3]);
        check_bit("gt_tx_pma_reset", gt_tx_pma_reset, bits[0]);
        check_bit("gt_tx_pcs_reset", gt_tx_pcs_reset, bits[1]);
        {eyescan_reset, rx_dfe_lpm_reset, rx_pcs_reset, rx_pma_reset} = 4'h0;
        {tx_pcs_reset, tx_pma_reset} = 2'b00;
        rx_reset = 1'b0;
        step(1);
        check_bit("gt_rx_pma_reset", gt_rx_pma_reset, 1'b0);
        check_bit("gt_rx_pcs_reset", gt_rx_pcs_reset, 1'b0);
        check_bit("gt_rx_dfe_lpm_reset", gt_rx_dfe_lpm_reset, 1'b0);
        check_bit("gt_rx_eyescan_reset", gt_rx_eyescan_reset, 1'b0);
        check_bit("gt_tx_pma_reset", gt_tx_pma_reset, 1'b0);
        check_bit("gt_tx_pcs_reset", gt_tx_pcs_reset, 1'b0);
        check_rx_down();
        wait_settle(exp, 1'b1, waited);
    endtask

    task automatic check_final(input logic [3:0] exp);
        check_bit("rx_reset_done", rx_reset_done, exp[3]);
        check_bit("gt_rx_userrdy", gt_rx_userrdy, exp[2]);
        check_bit("tx_reset_done", tx_reset_done, exp[1]);
        check_bit("gt_tx_userrdy", gt_tx_userrdy, exp[0]);
        check_bit("rx_prgdiv_reset_done", rx_prgdiv_reset_done, exp[3]);
        check_bit("tx_prgdiv_reset_done", tx_prgdiv_reset_done, exp[1]);
        check_bit("rx_pma_reset_done", rx_pma_reset_done, 1'b1);
        check_bit("tx_pma_reset_done", tx_pma_reset_done, 1'b1);
        check_bit("gt_rx_reset", gt_rx_reset, !exp[3]);
        check_bit("gt_tx_reset", gt_tx_reset, !exp[1]);
        check_bit("gt_rx_pd", gt_rx_pd, !exp[3]);
        check_bit("gt_tx_pd", gt_tx_pd, tx_pd);
        check_bit("gt_rx_lpm_en", gt_rx_lpm_en, rx_lpm_en);
        check_bit("gt_tx_qpll_sel", gt_tx_qpll_sel, tx_qpll_sel);
    endtask

    task automatic run_test(input int idx);
        logic [3:0] exp;
        exp = t_exp[idx];
        cdr_en = t_cdr[idx];
        test_errors = 0;
        done_dly = 1 + ($random(seed) & 3);
        clk_dly = 1 + ($random(seed) & 3);
        cdr_dly = 1 + ($random(seed) & 7);
        case (t_code[idx])
            1: power_up(exp);
            2: lock_loss(t_arg[idx], exp);
            3: sel_change(t_arg[idx], exp);
            4: cdr_restart(exp);
            5: pd_hold(t_arg[idx], exp);
            6: reset_pulse(t_arg[idx], exp);
            default: begin
                $display("test %0d has an unknown scenario code %0d", idx, t_code[idx]);
                note_error();
            end
        endcase
        check_final(exp);
        if (test_errors == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d scenario %0d: %s", idx, t_code[idx],
                 (test_errors == 0) ? "pass" : "fail");
    endtask

    task automatic load_tests();
        int    fd;
        int    rc;
        int    code, arg, cdr, e3, e2, e1, e0;
        string line;
        fd = $fopen("testbench/gt_reset_tests.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                rc = $sscanf(line, "%h %h %h %h %h %h %h", code, arg, cdr, e3, e2, e1, e0);
                if (rc == 7) begin
                    t_code.push_back(code);
                    t_arg.push_back(arg);
                    t_cdr.push_back(cdr[0]);
                    t_exp.push_back({e3[0], e2[0], e1[0], e0[0]});
                    cycle_limit += 3 * SEQ_WINDOW + arg + 16;
                end
            end
            $fclose(fd);
            loaded = t_code.size() > 0;
        end
    endtask

    initial begin
        rst = 1'b1;
        {qpll0_lock, qpll1_lock} = 2'b00;
        {gt_rx_reset_done, gt_userclk_rx_active, gt_rx_pma_reset_done} = 3'b000;
        {gt_rx_prgdiv_reset_done, gt_rx_cdr_lock} = 2'b00;
        {rx_reset, rx_pma_reset, rx_pcs_reset, rx_dfe_lpm_reset, eyescan_reset} = 5'b00000;
        {rx_pd, rx_qpll_sel, rx_lpm_en} = 3'b000;
        {gt_tx_reset_done, gt_userclk_tx_active, gt_tx_pma_reset_done} = 3'b000;
        gt_tx_prgdiv_reset_done = 1'b0;
        {tx_reset, tx_pma_reset, tx_pcs_reset, tx_pd, tx_qpll_sel} = 5'b00000;
        load_tests();
        if (!loaded) begin
            $display("no tests could be read from testbench/gt_reset_tests.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            for (int i = 0; i < t_code.size(); i++) begin
                run_test(i);
            end
            $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                     t_code.size(), passed, failed, errors);
            if (errors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

// File: testbench/gt_reset_tests.txt
# columns in hex: scenario arg cdr_en rx_done rx_rdy tx_done tx_rdy
# scenarios: 1 power-up, 2 lock loss, 3 rx select, 4 rx restart, 5 rx power-down, 6 rx reset
1 0 1 1 1 1 1
2 5 1 1 1 1 1
3 1 1 1 1 1 1
3 0 1 1 1 1 1
4 0 0 1 1 1 1
2 c 0 1 1 1 1
5 0 1 0 0 1 1
5 10 1 1 1 1 1
6 f 1 1 1 1 1
6 5 1 1 1 1 1
6 a 0 1 1 1 1
4 0 1 1 1 1 1
1 0 1 1 1 1 1

// File: sources.f
src/gt_reset_pkg.sv
src/sync_signal.sv
src/sync_reset.sv
src/gt_rx_reset.sv
src/gt_tx_reset.sv
src/gt_reset_top.sv
testbench/gt_reset_tb.sv
